// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

	typedef logic [31:0] word_t;

	// byte address, bits 9:2 pick the ram word and the bits above wrap.
	typedef logic [31:0] addr_t;

	localparam int RAM_WORDS = 256;
	typedef logic [7:0] ram_index_t;

	// one word per line.
	localparam int IC_LINES = 16;
	typedef logic [3:0] ic_index_t;
	typedef logic [3:0] ic_tag_t;

	// bit positions in the arbiter request and acknowledge vectors.
	localparam int MASTER_IC = 0;
	localparam int MASTER_DP = 1;

	typedef struct packed
	{
		addr_t addr;
		word_t wdata;
		logic rd;
		logic wr;
	} bus_cmd_t;

	typedef enum logic [1:0]
	{
		IC_IDLE,
		IC_REQ,
		IC_WAIT,
		IC_RELEASE
	} ic_state_t;

	typedef enum logic [1:0]
	{
		DP_IDLE,
		DP_REQ,
		DP_WAIT,
		DP_RELEASE
	} dp_state_t;

endpackage

`default_nettype wire

// File: inst_cache.sv
`default_nettype none

module inst_cache
(
	input wire clk,
	input wire rst_n,
	input wire rd_req,
	input wire mem_pkg::addr_t rd_addr,
	output logic rd_wait,
	output mem_pkg::word_t rd_data,
	output logic bus_req,
	input wire bus_ack,
	output mem_pkg::bus_cmd_t bus_cmd,
	input wire mem_pkg::word_t bus_rdata,
	input wire bus_ready
);
	import mem_pkg::*;

	ic_state_t state;

	logic [IC_LINES-1:0] valid;
	ic_tag_t tags [IC_LINES];
	word_t lines [IC_LINES];

	ic_index_t idx;
	ic_tag_t tag;
	logic hit;
	logic fill_done;

	addr_t fill_addr;
	logic fill_rd;

	assign idx = rd_addr[5:2];
	assign tag = rd_addr[9:6];
	assign hit = valid[idx] && (tags[idx] == tag);
	assign fill_done = (state == IC_WAIT) && bus_ack && bus_ready;

	// hits complete in the request cycle and misses when the ram answers.
	assign rd_wait = rd_req && !hit && !fill_done;
	assign rd_data = fill_done ? bus_rdata : lines[idx];

	assign bus_req = (state == IC_REQ) || (state == IC_WAIT) ||
		((state == IC_IDLE) && rd_req && !hit);

	always_comb
	begin
		bus_cmd = '0;
		bus_cmd.addr = fill_addr;
		bus_cmd.rd = fill_rd;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IC_IDLE;
			fill_rd <= 1'b0;
		end
		else
		begin
			fill_rd <= 1'b0;
			case (state)
				IC_IDLE:
					if (rd_req && !hit)
						state <= IC_REQ;
				IC_REQ:
					if (bus_ack)
					begin
						fill_rd <= 1'b1;
						state <= IC_WAIT;
					end
				IC_WAIT:
					if (fill_done)
						state <= IC_RELEASE;
				IC_RELEASE:
					// the next request waits for the grant to fall.
					if (!bus_ack)
						state <= IC_IDLE;
				default:
					state <= IC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid <= '0;
		else if (fill_done)
			valid[idx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if ((state == IC_REQ) && bus_ack)
			fill_addr <= rd_addr;
		if (fill_done)
		begin
			tags[idx] <= tag;
			lines[idx] <= bus_rdata;
		end
	end

	// a pending miss keeps its request up until the ram has answered.
	a_hold_req: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_req && !fill_done) |=> bus_req);

	// the read strobe only goes out under the grant.
	a_read_only: assert property (@(posedge clk) disable iff (!rst_n)
		!bus_cmd.wr && (!bus_cmd.rd || bus_ack));

endmodule

`default_nettype wire

// File: data_port.sv
`default_nettype none

module data_port
(
	input wire clk,
	input wire rst_n,
	input wire mem_pkg::addr_t addr,
	input wire rd_req,
	input wire wr_req,
	output logic rw_wait,
	input wire mem_pkg::word_t wr_data,
	output mem_pkg::word_t rd_data,
	output logic bus_req,
	input wire bus_ack,
	output mem_pkg::bus_cmd_t bus_cmd,
	input wire mem_pkg::word_t bus_rdata,
	input wire bus_ready
);
	import mem_pkg::*;

	dp_state_t state;
	logic active;
	logic done;

	addr_t cmd_addr;
	word_t cmd_wdata;
	logic cmd_rd;
	logic cmd_wr;
	word_t rdata_q;

	assign active = rd_req || wr_req;
	assign done = (state == DP_WAIT) && bus_ack && bus_ready;

	assign rw_wait = active && !done;
	assign rd_data = done ? bus_rdata : rdata_q;

	assign bus_req = (state == DP_REQ) || (state == DP_WAIT) ||
		((state == DP_IDLE) && active);

	assign bus_cmd = '{addr: cmd_addr, wdata: cmd_wdata, rd: cmd_rd, wr: cmd_wr};

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= DP_IDLE;
			cmd_rd <= 1'b0;
			cmd_wr <= 1'b0;
		end
		else
		begin
			cmd_rd <= 1'b0;
			cmd_wr <= 1'b0;
			case (state)
				DP_IDLE:
					if (active)
						state <= DP_REQ;
				DP_REQ:
					if (bus_ack)
					begin
						cmd_rd <= rd_req;
						cmd_wr <= wr_req;
						state <= DP_WAIT;
					end
				DP_WAIT:
					if (done)
						state <= DP_RELEASE;
				DP_RELEASE:
					if (!bus_ack)
						state <= DP_IDLE;
				default:
					state <= DP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == DP_REQ) && bus_ack)
		begin
			cmd_addr <= addr;
			cmd_wdata <= wr_data;
		end
		if (done)
			rdata_q <= bus_rdata;
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd_req && wr_req));

	// the memory stage holds its request until it has completed.
	a_client_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(active && rw_wait) |=> active);

endmodule

`default_nettype wire

// File: bus_arbiter.sv
`default_nettype none

module bus_arbiter
(
	input wire clk,
	input wire rst_n,
	input wire [1:0] req,
	output logic [1:0] ack,
	input wire mem_pkg::bus_cmd_t cmd_ic,
	input wire mem_pkg::bus_cmd_t cmd_dp,
	output mem_pkg::bus_cmd_t cmd
);
	import mem_pkg::*;

	logic [1:0] ack_next;

	// a new grant only once the previous one has fallen and with the data port first.
	always_comb
	begin
		ack_next = ack;
		if (ack == 2'b00)
		begin
			if (req[MASTER_DP])
				ack_next[MASTER_DP] = 1'b1;
			else if (req[MASTER_IC])
				ack_next[MASTER_IC] = 1'b1;
		end
		else if ((req & ack) == 2'b00)
			ack_next = 2'b00;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ack <= 2'b00;
		else
			ack <= ack_next;
	end

	always_comb
	begin
		if (ack[MASTER_DP])
			cmd = cmd_dp;
		else if (ack[MASTER_IC])
			cmd = cmd_ic;
		else
			cmd = '0;
	end

	a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(ack));

endmodule

`default_nettype wire

// File: block_ram.sv
`default_nettype none

module block_ram
(
	input wire clk,
	input wire mem_pkg::bus_cmd_t cmd,
	output mem_pkg::word_t rdata,
	output logic ready = 1'b0
);
	import mem_pkg::*;

	word_t mem [RAM_WORDS];
	ram_index_t idx;

	assign idx = cmd.addr[9:2];

	always_ff @(posedge clk)
	begin
		if (cmd.wr)
			mem[idx] <= cmd.wdata;
		if (cmd.rd)
			rdata <= mem[idx];
	end

	// one strobe per command, the cycle after it was sampled.
	always_ff @(posedge clk)
	begin
		ready <= cmd.rd || cmd.wr;
	end

endmodule

`default_nettype wire

// File: mem_system.sv
`default_nettype none

module mem_system
(
	input wire clk,
	input wire rst_n,
	input wire if_req,
	input wire mem_pkg::addr_t if_addr,
	output logic if_wait,
	output mem_pkg::word_t if_data,
	input wire mem_pkg::addr_t dm_addr,
	input wire dm_rd_req,
	input wire dm_wr_req,
	input wire mem_pkg::word_t dm_wr_data,
	output logic dm_wait,
	output mem_pkg::word_t dm_rd_data
);
	import mem_pkg::*;

	logic [1:0] bus_req;
	logic [1:0] bus_ack;
	bus_cmd_t cmd_ic;
	bus_cmd_t cmd_dp;
	bus_cmd_t cmd_ram;
	word_t ram_rdata;
	logic ram_ready;

	inst_cache icache
	(
		.clk(clk),
		.rst_n(rst_n),
		.rd_req(if_req),
		.rd_addr(if_addr),
		.rd_wait(if_wait),
		.rd_data(if_data),
		.bus_req(bus_req[MASTER_IC]),
		.bus_ack(bus_ack[MASTER_IC]),
		.bus_cmd(cmd_ic),
		.bus_rdata(ram_rdata),
		.bus_ready(ram_ready)
	);

	data_port dport
	(
		.clk(clk),
		.rst_n(rst_n),
		.addr(dm_addr),
		.rd_req(dm_rd_req),
		.wr_req(dm_wr_req),
		.rw_wait(dm_wait),
		.wr_data(dm_wr_data),
		.rd_data(dm_rd_data),
		.bus_req(bus_req[MASTER_DP]),
		.bus_ack(bus_ack[MASTER_DP]),
		.bus_cmd(cmd_dp),
		.bus_rdata(ram_rdata),
		.bus_ready(ram_ready)
	);

	bus_arbiter arbiter
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(bus_req),
		.ack(bus_ack),
		.cmd_ic(cmd_ic),
		.cmd_dp(cmd_dp),
		.cmd(cmd_ram)
	);

	block_ram ram
	(
		.clk(clk),
		.cmd(cmd_ram),
		.rdata(ram_rdata),
		.ready(ram_ready)
	);

endmodule

`default_nettype wire

// File: tb_mem_system.sv
`default_nettype none

module tb_mem_system;
	timeunit 1ns;
	timeprecision 1ps;
	import mem_pkg::*;

	localparam int PERIOD = 100;
	localparam int SEED = 71407;
	localparam int N_LOADS = 64;
	localparam int N_PAIRS = 8;
	localparam int N_EVICT = 8;
	localparam int N_COHERE = 4;
	localparam int N_MIXED = 200;
	localparam int NUM_OPS = RAM_WORDS + N_LOADS + 2 * N_PAIRS + 2 * N_EVICT +
		5 * N_COHERE + 2 * N_MIXED + IC_LINES;
	localparam int LIMIT_CYCLES = NUM_OPS * 20 + 100;

	logic clk;
	logic rst_n;
	logic if_req;
	addr_t if_addr;
	logic if_wait;
	word_t if_data;
	addr_t dm_addr;
	logic dm_rd_req;
	logic dm_wr_req;
	word_t dm_wr_data;
	logic dm_wait;
	word_t dm_rd_data;

	// reference model of the ram and of the cache contents.
	word_t ram_image [RAM_WORDS];
	logic cache_valid [IC_LINES];
	ic_tag_t cache_tag [IC_LINES];
	word_t cache_word [IC_LINES];

	int errors;
	int checks;

	mem_system UUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.if_req(if_req),
		.if_addr(if_addr),
		.if_wait(if_wait),
		.if_data(if_data),
		.dm_addr(dm_addr),
		.dm_rd_req(dm_rd_req),
		.dm_wr_req(dm_wr_req),
		.dm_wr_data(dm_wr_data),
		.dm_wait(dm_wait),
		.dm_rd_data(dm_rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		repeat (LIMIT_CYCLES)
			@(posedge clk);
		$display("timeout: a request did not complete within %0d cycles", LIMIT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic check_word(input string what, input word_t exp, input word_t got);
		checks++;
		assert (got == exp)
		else
		begin
			$display("Error at %0t: %s expected %h, got %h", $time, what, exp, got);
			errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic got);
		checks++;
		assert (got == exp)
		else
		begin
			$display("Error at %0t: %s expected %0b, got %0b", $time, what, exp, got);
			errors++;
		end
	endtask

	// random bits around the word index and upper bits only when wrapping.
	function automatic addr_t rand_addr(input ram_index_t widx, input logic wrap);
		addr_t a;
		a = $urandom;
		if (!wrap)
			a[31:10] = '0;
		a[9:2] = widx;
		return a;
	endfunction

	// tasks below start and end on a falling edge.
	task automatic apply_reset();
		if_req = 1'b0;
		dm_rd_req = 1'b0;
		dm_wr_req = 1'b0;
		rst_n = 1'b0;
		repeat (2)
			@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < IC_LINES; i++)
			cache_valid[i] = 1'b0;
	endtask

	task automatic data_access(input logic write, input addr_t addr, input word_t wdata);
		ram_index_t widx;
		widx = addr[9:2];
		dm_addr = addr;
		dm_rd_req = !write;
		dm_wr_req = write;
		dm_wr_data = wdata;
		#1;
		check_flag("data port wait", 1'b1, dm_wait);
		while (dm_wait)
		begin
			@(negedge clk);
			#1;
		end
		if (write)
			ram_image[widx] = wdata;
		else
			check_word("load data", ram_image[widx], dm_rd_data);
		@(negedge clk);
		dm_rd_req = 1'b0;
		dm_wr_req = 1'b0;
	endtask

	task automatic fetch(input addr_t addr);
		ic_index_t idx;
		ic_tag_t tag;
		logic exp_hit;
		word_t exp;
		idx = addr[5:2];
		tag = addr[9:6];
		exp_hit = cache_valid[idx] && (cache_tag[idx] == tag);
		exp = exp_hit ? cache_word[idx] : ram_image[addr[9:2]];
		if_addr = addr;
		if_req = 1'b1;
		#1;
		check_flag("fetch hit", exp_hit, !if_wait);
		while (if_wait)
		begin
			@(negedge clk);
			#1;
		end
		check_word("fetch data", exp, if_data);
		if (!exp_hit)
		begin
			cache_valid[idx] = 1'b1;
			cache_tag[idx] = tag;
			cache_word[idx] = exp;
		end
		@(negedge clk);
		if_req = 1'b0;
	endtask

	initial
	begin
		ram_index_t order [RAM_WORDS];
		ram_index_t tmp;
		int j;
		addr_t a;
		addr_t b;
		word_t w;
		addr_t cached [$];

		void'($urandom(SEED));
		errors = 0;
		checks = 0;
		if_req = 1'b0;
		if_addr = '0;
		dm_addr = '0;
		dm_rd_req = 1'b0;
		dm_wr_req = 1'b0;
		dm_wr_data = '0;
		rst_n = 1'b0;
		apply_reset();

		// stores to every word in shuffled order and then random loads.
		for (int i = 0; i < RAM_WORDS; i++)
			order[i] = ram_index_t'(i);
		for (int i = RAM_WORDS - 1; i > 0; i--)
		begin
			j = int'($urandom_range(i));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < RAM_WORDS; i++)
			data_access(1'b1, rand_addr(order[i], 1'b0), $urandom);
		for (int i = 0; i < N_LOADS; i++)
			data_access(1'b0, rand_addr(ram_index_t'($urandom), 1'b1), '0);

		// lines 0 to 7 are cold here so each first fetch misses.
		for (int i = 0; i < N_PAIRS; i++)
		begin
			a = rand_addr(ram_index_t'({ic_tag_t'($urandom), ic_index_t'(i)}), 1'b1);
			fetch(a);
			fetch(a);
		end

		a = rand_addr(ram_index_t'($urandom), 1'b0);
		b = a;
		b[9:6] = a[9:6] ^ 4'h5;
		for (int i = 0; i < N_EVICT; i++)
		begin
			fetch(a);
			fetch(b);
		end

		// the cached copy stays stale after a store until it is evicted.
		for (int i = 0; i < N_COHERE; i++)
		begin
			a = rand_addr(ram_index_t'($urandom), 1'b0);
			b = a;
			b[9:6] = a[9:6] ^ 4'h9;
			fetch(a);
			w = ~ram_image[a[9:2]];
			data_access(1'b1, a, w);
			fetch(a);
			fetch(b);
			fetch(a);
		end

		// fetches stay in the lower half and stores go to the upper half.
		fork
			for (int i = 0; i < N_MIXED; i++)
				fetch(rand_addr(ram_index_t'($urandom_range(127)), $urandom_range(1) != 0));
			for (int i = 0; i < N_MIXED; i++)
			begin
				if ($urandom_range(1) != 0)
					data_access(1'b1, rand_addr(ram_index_t'(128 + $urandom_range(127)),
						$urandom_range(1) != 0), $urandom);
				else
					data_access(1'b0, rand_addr(ram_index_t'($urandom),
						$urandom_range(1) != 0), '0);
			end
		join

		for (int i = 0; i < IC_LINES; i++)
		begin
			if (cache_valid[i])
			begin
				a = '0;
				a[9:6] = cache_tag[i];
				a[5:2] = ic_index_t'(i);
				cached.push_back(a);
			end
		end
		apply_reset();
		foreach (cached[i])
			fetch(cached[i]);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
mem_pkg.sv
inst_cache.sv
data_port.sv
bus_arbiter.sv
block_ram.sv
mem_system.sv
tb_mem_system.sv

// File: Makefile
# Verilator build and run of the memory system testbench.

TOP = tb_mem_system

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
